/* bootPkg.sv */
package bootPkg;

    // One processor or RAM data word
    typedef logic [31:0] word_t;

    // Pixel view of a bus address, coordinates in the upper half
    typedef struct packed {
        logic [7:0]  pixY;
        logic [7:0]  pixX;
        logic [15:0] offset;
    } pixelAddr_t;

    // Same address word, decoded either as a plain address or as a pixel
    typedef union packed {
        word_t      raw;
        pixelAddr_t pixel;
    } busAddr_t;

    typedef enum logic [2:0] {
        idle,
        readCount,
        copyWords,
        finish,
        running
    } loaderState_t;

    // Zero low half selects the frame buffer
    function automatic logic isPixelAddr(busAddr_t a);
        return a.pixel.offset == 16'h0000;
    endfunction

    // Zero high half with nonzero low half selects a RAM word
    function automatic logic isRamAddr(busAddr_t a);
        return (a.raw[31:16] == 16'h0000) && !isPixelAddr(a);
    endfunction

endpackage

/* videoPkg.sv */
package videoPkg;

    // 8-bit color value as stored in the frame buffer
    typedef logic [7:0] pixel_t;

    // Pixel coordinate on either axis
    typedef logic [7:0] coord_t;

endpackage

/* memBus.sv */
`timescale 1ns/1ps

interface memBus import bootPkg::*; #(
    parameter int RamAddrBits = 10
) ();

    logic [RamAddrBits-1:0] addr;
    word_t                  wdata;
    logic                   write;
    // Valid one cycle after addr
    word_t                  rdata;

    modport ramSide (
        input  addr,
        input  wdata,
        input  write,
        output rdata
    );

    modport hostSide (
        output addr,
        output wdata,
        output write,
        input  rdata
    );

endinterface

/* spiWordReader.sv */
`timescale 1ns/1ps

module spiWordReader import bootPkg::*; (
    input  logic  clk_25mhz,
    input  logic  reset,
    input  logic  readReq,
    input  word_t readAddr,
    output word_t readData,
    output logic  readDone,
    output logic  busy,
    output logic  spiCs,
    output logic  spiClk,
    output logic  spiMosi,
    input  logic  spiMiso
);

    localparam logic [7:0] ReadCmd = 8'h03;

    // 64 bits per transaction: command, address, then data
    logic [5:0]  bitCount;
    logic [31:0] outShift;
    logic        startRead;

    assign startRead = readReq && !busy;
    assign spiMosi   = outShift[31];

    // Control path, one bit every two clock cycles
    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            busy     <= 1'b0;
            spiCs    <= 1'b1;
            spiClk   <= 1'b0;
            readDone <= 1'b0;
            bitCount <= '0;
        end else begin
            readDone <= 1'b0;
            if (!busy) begin
                if (readReq) begin
                    busy     <= 1'b1;
                    spiCs    <= 1'b0;
                    bitCount <= '0;
                end
            end else if (!spiClk) begin
                spiClk <= 1'b1;
            end else begin
                spiClk   <= 1'b0;
                bitCount <= bitCount + 6'd1;
                // Last bit done, release the device
                if (bitCount == 6'd63) begin
                    busy     <= 1'b0;
                    spiCs    <= 1'b1;
                    readDone <= 1'b1;
                end
            end
        end
    end

    // Shift registers
    always_ff @(posedge clk_25mhz) begin
        if (startRead) begin
            outShift <= {ReadCmd, readAddr[23:0]};
        end else if (busy && spiClk) begin
            // Advance MOSI on the falling edge
            outShift <= {outShift[30:0], 1'b0};
        end

        // Sample MISO on the rising edge, data phase only
        if (busy && !spiClk && bitCount[5]) begin
            readData <= {readData[30:0], spiMiso};
        end
    end

endmodule

/* bootLoader.sv */
`timescale 1ns/1ps

module bootLoader import bootPkg::*; #(
    parameter int RamAddrBits = 10
) (
    input  logic                   clk_25mhz,
    input  logic                   reset,
    output logic                   readReq,
    output word_t                  readAddr,
    input  word_t                  readData,
    input  logic                   readDone,
    input  logic                   busy,
    output logic                   loadWrite,
    output logic [RamAddrBits-1:0] loadAddr,
    output word_t                  loadData,
    output logic                   bootDone,
    output loaderState_t           state
);

    // Image word count N from storage word 0
    word_t wordCount;
    // Storage word k lands in RAM word k-1
    word_t ramIndex;

    assign ramIndex = readAddr - 32'd1;

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            state     <= idle;
            readReq   <= 1'b0;
            readAddr  <= '0;
            loadWrite <= 1'b0;
            bootDone  <= 1'b0;
            wordCount <= '0;
        end else begin
            readReq   <= 1'b0;
            loadWrite <= 1'b0;
            case (state)
                idle: begin
                    // Fetch the count word first
                    if (!busy) begin
                        readAddr <= '0;
                        readReq  <= 1'b1;
                        state    <= readCount;
                    end
                end
                readCount: begin
                    if (readDone) begin
                        wordCount <= readData;
                        if (readData == '0) begin
                            state <= finish;
                        end else begin
                            readAddr <= 32'd1;
                            readReq  <= 1'b1;
                            state    <= copyWords;
                        end
                    end
                end
                copyWords: begin
                    if (readDone) begin
                        loadWrite <= 1'b1;
                        loadAddr  <= ramIndex[RamAddrBits-1:0];
                        loadData  <= readData;
                        if (readAddr == wordCount) begin
                            state <= finish;
                        end else begin
                            readAddr <= readAddr + 32'd1;
                            readReq  <= 1'b1;
                        end
                    end
                end
                finish: begin
                    // Last RAM write lands this cycle before the bus goes to the CPU
                    bootDone <= 1'b1;
                    state    <= running;
                end
                running: begin
                    state <= running;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* busRouter.sv */
`timescale 1ns/1ps

module busRouter import bootPkg::*, videoPkg::*; #(
    parameter int RamAddrBits = 10,
    parameter int FbCoordBits = 6
) (
    input  logic                   clk_25mhz,
    input  logic                   reset,
    input  logic                   cpuValid,
    input  logic                   cpuWrite,
    input  word_t                  cpuAddr,
    input  word_t                  cpuWdata,
    output logic                   cpuReady,
    output word_t                  cpuRdata,
    output logic                   cpuRdataValid,
    input  logic                   loadWrite,
    input  logic [RamAddrBits-1:0] loadAddr,
    input  word_t                  loadData,
    input  logic                   bootDone,
    memBus.hostSide                ram,
    output logic                   pixWrite,
    output coord_t                 pixX,
    output coord_t                 pixY,
    output pixel_t                 pixColor
);

    busAddr_t addr;
    logic     accept;
    logic     pixelSel;
    logic     ramSel;
    logic     pixInRange;
    logic     readUnmapped;

    assign addr.raw = cpuAddr;

    // No back-pressure once the loader is done
    assign cpuReady = bootDone;
    assign accept   = cpuValid && cpuReady;

    assign pixelSel   = isPixelAddr(addr);
    assign ramSel     = isRamAddr(addr);
    assign pixInRange = ((addr.pixel.pixX >> FbCoordBits) == '0) &&
                        ((addr.pixel.pixY >> FbCoordBits) == '0);

    // Loader owns the RAM until boot completes
    assign ram.addr  = bootDone ? addr.raw[RamAddrBits-1:0] : loadAddr;
    assign ram.wdata = bootDone ? cpuWdata : loadData;
    assign ram.write = bootDone ? (accept && cpuWrite && ramSel) : loadWrite;

    assign pixWrite = accept && cpuWrite && pixelSel && pixInRange;
    assign pixX     = addr.pixel.pixX;
    assign pixY     = addr.pixel.pixY;
    assign pixColor = cpuWdata[7:0];

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            cpuRdataValid <= 1'b0;
        end else begin
            cpuRdataValid <= accept && !cpuWrite;
        end
    end

    // Remember which reads must return zero
    always_ff @(posedge clk_25mhz) begin
        readUnmapped <= !pixelSel && !ramSel;
    end

    assign cpuRdata = readUnmapped ? '0 : ram.rdata;

endmodule

/* wordRam.sv */
`timescale 1ns/1ps

module wordRam import bootPkg::*; #(
    parameter int RamAddrBits = 10
) (
    input  logic   clk_25mhz,
    memBus.ramSide mem
);

    localparam int Depth = 2 ** RamAddrBits;

    word_t store [Depth];

    // Read returns the old word when written in the same cycle
    always_ff @(posedge clk_25mhz) begin
        if (mem.write) begin
            store[mem.addr] <= mem.wdata;
        end
        mem.rdata <= store[mem.addr];
    end

endmodule

/* frameBuffer.sv */
`timescale 1ns/1ps

module frameBuffer import videoPkg::*; #(
    parameter int FbCoordBits = 6
) (
    input  logic   clk_25mhz,
    input  logic   pixWrite,
    input  coord_t pixX,
    input  coord_t pixY,
    input  pixel_t pixColor,
    input  coord_t scanX,
    input  coord_t scanY,
    output pixel_t scanPixel
);

    localparam int FbSize = 2 ** FbCoordBits;

    // Indexed as row, then column
    pixel_t pixels [FbSize][FbSize];

    // Screen starts black
    initial begin
        for (int y = 0; y < FbSize; y++) begin
            for (int x = 0; x < FbSize; x++) begin
                pixels[y][x] = '0;
            end
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (pixWrite) begin
            pixels[pixY[FbCoordBits-1:0]][pixX[FbCoordBits-1:0]] <= pixColor;
        end
        scanPixel <= pixels[scanY[FbCoordBits-1:0]][scanX[FbCoordBits-1:0]];
    end

endmodule

/* bootSystem.sv */
`timescale 1ns/1ps

module bootSystem import bootPkg::*, videoPkg::*; #(
    parameter int RamAddrBits = 10,
    parameter int FbCoordBits = 6
) (
    input  logic       clk_25mhz,
    input  logic       reset,
    output logic       spiCs,
    output logic       spiClk,
    output logic       spiMosi,
    input  logic       spiMiso,
    input  logic       cpuValid,
    input  logic       cpuWrite,
    input  word_t      cpuAddr,
    input  word_t      cpuWdata,
    output logic       cpuReady,
    output word_t      cpuRdata,
    output logic       cpuRdataValid,
    input  coord_t     scanX,
    input  coord_t     scanY,
    output pixel_t     scanPixel,
    output logic [7:0] led
);

    // Storage reads
    logic  readReq;
    word_t readAddr;
    word_t readData;
    logic  readDone;
    logic  readBusy;

    // Loader to router
    logic                   loadWrite;
    logic [RamAddrBits-1:0] loadAddr;
    word_t                  loadData;
    logic                   bootDone;
    loaderState_t           loaderState;

    // Router to frame buffer
    logic   pixWrite;
    coord_t pixX;
    coord_t pixY;
    pixel_t pixColor;

    memBus #(.RamAddrBits(RamAddrBits)) ramBus ();

    // Status: loader state low, boot done above it
    assign led = {4'b0000, bootDone, loaderState};

    spiWordReader reader (
        .clk_25mhz(clk_25mhz),
        .reset    (reset),
        .readReq  (readReq),
        .readAddr (readAddr),
        .readData (readData),
        .readDone (readDone),
        .busy     (readBusy),
        .spiCs    (spiCs),
        .spiClk   (spiClk),
        .spiMosi  (spiMosi),
        .spiMiso  (spiMiso)
    );

    bootLoader #(.RamAddrBits(RamAddrBits)) loader (
        .clk_25mhz(clk_25mhz),
        .reset    (reset),
        .readReq  (readReq),
        .readAddr (readAddr),
        .readData (readData),
        .readDone (readDone),
        .busy     (readBusy),
        .loadWrite(loadWrite),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .bootDone (bootDone),
        .state    (loaderState)
    );

    busRouter #(
        .RamAddrBits(RamAddrBits),
        .FbCoordBits(FbCoordBits)
    ) router (
        .clk_25mhz    (clk_25mhz),
        .reset        (reset),
        .cpuValid     (cpuValid),
        .cpuWrite     (cpuWrite),
        .cpuAddr      (cpuAddr),
        .cpuWdata     (cpuWdata),
        .cpuReady     (cpuReady),
        .cpuRdata     (cpuRdata),
        .cpuRdataValid(cpuRdataValid),
        .loadWrite    (loadWrite),
        .loadAddr     (loadAddr),
        .loadData     (loadData),
        .bootDone     (bootDone),
        .ram          (ramBus),
        .pixWrite     (pixWrite),
        .pixX         (pixX),
        .pixY         (pixY),
        .pixColor     (pixColor)
    );

    wordRam #(.RamAddrBits(RamAddrBits)) ram (
        .clk_25mhz(clk_25mhz),
        .mem      (ramBus)
    );

    frameBuffer #(.FbCoordBits(FbCoordBits)) frame (
        .clk_25mhz(clk_25mhz),
        .pixWrite (pixWrite),
        .pixX     (pixX),
        .pixY     (pixY),
        .pixColor (pixColor),
        .scanX    (scanX),
        .scanY    (scanY),
        .scanPixel(scanPixel)
    );

endmodule

/* bootSystemTb.sv */
`timescale 1ns/1ps

module bootSystemTb import bootPkg::*, videoPkg::*;;

    localparam int RamAddrBits   = 10;
    localparam int FbCoordBits   = 6;
    localparam int ImageWords    = 12;
    localparam int WriteBase     = 13;
    localparam int PixelWrites   = 6;
    localparam int ScanBase      = 19;
    localparam int ScanChecks    = 4;
    localparam int PatternWords  = 23;
    localparam int RandomWrites  = 20;
    localparam int TimeoutCycles = (ImageWords + 1) * 140 + 2000;

    logic       clk_25mhz = 1'b0;
    logic       reset;
    logic       spiCs;
    logic       spiClk;
    logic       spiMosi;
    logic       spiMiso = 1'b0;
    logic       cpuValid;
    logic       cpuWrite;
    word_t      cpuAddr;
    word_t      cpuWdata;
    logic       cpuReady;
    word_t      cpuRdata;
    logic       cpuRdataValid;
    coord_t     scanX;
    coord_t     scanY;
    pixel_t     scanPixel;
    logic [7:0] led;

    logic [31:0] patterns [0:PatternWords-1];
    logic [31:0] ramModel [0:(2**RamAddrBits)-1];
    int          writeIdx [0:RandomWrites-1];
    logic [31:0] rngState = 32'he4455f69;
    int          errorCount = 0;
    int          testErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          cycleCount = 0;

    // SPI storage slave state
    int          slaveBits = 0;
    logic [31:0] cmdAddr = '0;
    logic [31:0] dataShift = '0;

    bootSystem #(
        .RamAddrBits(RamAddrBits),
        .FbCoordBits(FbCoordBits)
    ) UUT (
        .clk_25mhz    (clk_25mhz),
        .reset        (reset),
        .spiCs        (spiCs),
        .spiClk       (spiClk),
        .spiMosi      (spiMosi),
        .spiMiso      (spiMiso),
        .cpuValid     (cpuValid),
        .cpuWrite     (cpuWrite),
        .cpuAddr      (cpuAddr),
        .cpuWdata     (cpuWdata),
        .cpuReady     (cpuReady),
        .cpuRdata     (cpuRdata),
        .cpuRdataValid(cpuRdataValid),
        .scanX        (scanX),
        .scanY        (scanY),
        .scanPixel    (scanPixel),
        .led          (led)
    );

    always #20 clk_25mhz = ~clk_25mhz;

    function logic [31:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // Words past the image read as zero
    function logic [31:0] storageWord(input logic [23:0] addr);
        if (addr <= ImageWords) begin
            return patterns[addr];
        end
        return 32'h0;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s expected %h actual %h", name, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("%s finished with %0d mismatches", name, testErrors);
        testErrors = 0;
    endtask

    // Called and returns on a falling edge
    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data);
        cpuValid = 1'b1;
        cpuWrite = 1'b1;
        cpuAddr  = addr;
        cpuWdata = data;
        while (!cpuReady) @(negedge clk_25mhz);
        @(negedge clk_25mhz);
        cpuValid = 1'b0;
        cpuWrite = 1'b0;
    endtask

    task automatic busRead(input logic [31:0] addr, input string name,
                           output logic [31:0] data);
        cpuValid = 1'b1;
        cpuWrite = 1'b0;
        cpuAddr  = addr;
        while (!cpuReady) @(negedge clk_25mhz);
        @(negedge clk_25mhz);
        cpuValid = 1'b0;
        checkValue({name, " rdataValid"}, 32'd1, cpuRdataValid);
        data = cpuRdata;
        // Valid for exactly one cycle
        @(negedge clk_25mhz);
        checkValue({name, " rdataValid end"}, 32'd0, cpuRdataValid);
    endtask

    task automatic scanRead(input coord_t x, input coord_t y, output pixel_t pixel);
        scanX = x;
        scanY = y;
        @(negedge clk_25mhz);
        pixel = scanPixel;
    endtask

    // SPI storage model in mode 0
    always @(posedge spiClk or negedge spiClk or posedge spiCs) begin
        if (spiCs) begin
            slaveBits <= 0;
            spiMiso   <= 1'b0;
        end else if (spiClk) begin
            if (slaveBits < 32) begin
                cmdAddr <= {cmdAddr[30:0], spiMosi};
            end
            slaveBits <= slaveBits + 1;
        end else if (slaveBits == 32) begin
            checkValue("spiCommand", 32'h03, {24'h0, cmdAddr[31:24]});
            dataShift = storageWord(cmdAddr[23:0]);
            spiMiso <= dataShift[31];
        end else if (slaveBits > 32 && slaveBits < 64) begin
            spiMiso <= dataShift[63 - slaveBits];
        end
    end

    always @(posedge clk_25mhz) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TimeoutCycles) begin
            if (!cpuReady) begin
                $display("Timeout after %0d cycles, cpuReady never rose", cycleCount);
            end else begin
                $display("Timeout after %0d cycles with tests still running", cycleCount);
            end
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] value;
        logic [31:0] entry;
        pixel_t      pixel;
        int          waitCycles;
        int          idx;

        reset    = 1'b1;
        cpuValid = 1'b0;
        cpuWrite = 1'b0;
        cpuAddr  = '0;
        cpuWdata = '0;
        scanX    = '0;
        scanY    = '0;

        $readmemh("bootSystemPatterns.hex", patterns);
        checkValue("patternFile", ImageWords, patterns[0]);
        for (int i = 0; i < ImageWords; i++) begin
            ramModel[i] = patterns[i + 1];
        end

        // Boot handoff
        repeat (16) @(negedge clk_25mhz);
        checkValue("resetState", 32'd0, cpuReady);
        checkValue("resetState", 32'd0, cpuRdataValid);
        checkValue("resetState", 32'd1, spiCs);
        checkValue("resetState", 32'd0, spiClk);
        checkValue("resetState", 32'd0, led);
        reset = 1'b0;
        waitCycles = 0;
        while (!cpuReady) begin
            checkValue("bootHandoff", 32'd0, led[3]);
            @(negedge clk_25mhz);
            waitCycles++;
        end
        // Each storage word needs a full 128-cycle transaction
        if (waitCycles < (ImageWords + 1) * 128) begin
            $display("bootHandoff cpuReady rose after only %0d cycles, before loading ended",
                     waitCycles);
            errorCount++;
            testErrors++;
        end
        checkValue("bootHandoff", {24'h0, 4'b0000, 1'b1, running}, led);
        finishTest("bootHandoff");

        // Image in RAM with address 0 reading RAM word 0
        for (int i = 0; i < ImageWords; i++) begin
            busRead(i, "imageInRam", value);
            checkValue("imageInRam", patterns[i + 1], value);
        end
        finishTest("imageInRam");

        // Random RAM writes above index 0 since 0 is a pixel address
        for (int i = 0; i < RandomWrites; i++) begin
            value = nextRandom();
            idx = 1 + (value[31:16] % 1023);
            value = nextRandom();
            writeIdx[i] = idx;
            ramModel[idx] = value;
            busWrite(idx, value);
        end
        for (int i = 0; i < RandomWrites; i++) begin
            busRead(writeIdx[i], "ramWriteRead", value);
            checkValue("ramWriteRead", ramModel[writeIdx[i]], value);
        end
        finishTest("ramWriteRead");

        // Pixel entries are y, x, unused byte, color
        for (int i = 0; i < PixelWrites; i++) begin
            entry = patterns[WriteBase + i];
            value = nextRandom();
            busWrite({entry[31:16], 16'h0000}, {value[31:8], entry[7:0]});
        end
        for (int i = 0; i < PixelWrites; i++) begin
            entry = patterns[WriteBase + i];
            scanRead(entry[23:16], entry[31:24], pixel);
            checkValue("pixelWrites", {24'h0, entry[7:0]}, pixel);
        end
        for (int i = 0; i < ScanChecks; i++) begin
            entry = patterns[ScanBase + i];
            scanRead(entry[23:16], entry[31:24], pixel);
            checkValue("pixelWrites", {24'h0, entry[7:0]}, pixel);
        end
        finishTest("pixelWrites");

        // Ignored accesses
        busRead(32'h1234_5678, "ignoredAccesses", value);
        checkValue("ignoredAccesses", 32'h0, value);
        busRead(32'h0000_0005, "ignoredAccesses", value);
        checkValue("ignoredAccesses", ramModel[5], value);
        busWrite(32'h0001_0005, ~ramModel[5]);
        busRead(32'h0000_0005, "ignoredAccesses", value);
        checkValue("ignoredAccesses", ramModel[5], value);
        // x = 70 would alias onto column 6 if not dropped
        busWrite({8'h05, 8'h46, 16'h0000}, 32'h0000_00ff);
        scanRead(8'h06, 8'h05, pixel);
        checkValue("ignoredAccesses", 32'h0, pixel);
        finishTest("ignoredAccesses");

        $display("%0d tests run, %0d failed, %0d mismatches in total",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* bootSystemPatterns.hex */
// Storage image word count, then the 12 image words
// Then 6 pixel writes and 4 scan checks, each as y x 00 color
0000000c
8c3a51e7
0f1e2d3c
13579bdf
2468ace0
5a5aa5a5
7c01ff3e
91d3b40a
a0b1c2d3
c3e4f506
e1f00d17
3b6d9f21
6f0d2a8c
050300a5
1020003c
3f3f007e
00010011
220000c8
012a005f
050300a5
05040000
3f3e0000
00000000

/* bootSystem.f */
bootPkg.sv
videoPkg.sv
memBus.sv
spiWordReader.sv
bootLoader.sv
busRouter.sv
wordRam.sv
frameBuffer.sv
bootSystem.sv
bootSystemTb.sv

/* Bender.yml */
package:
  name: bootSystem

sources:
  - bootPkg.sv
  - videoPkg.sv
  - memBus.sv
  - spiWordReader.sv
  - bootLoader.sv
  - busRouter.sv
  - wordRam.sv
  - frameBuffer.sv
  - bootSystem.sv
  - target: simulation
    files:
      - bootSystemTb.sv
